// File: design/ctrl_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// ***************************************************************************
// Datapath widths
// ***************************************************************************

`define OPCODE_W 8

// Wide enough for T1..T7.
`define CYCLE_W 3

// ***************************************************************************
// Cycle counts per instruction class
// ***************************************************************************

// Unknown opcodes run as implied.
`define CYC_IMPL 2
`define CYC_IMM 2
`define CYC_ABS 4
`define CYC_JMP 3
`define CYC_JSR 6
`define CYC_RTS 6

`endif

// File: design/ctrlPkg.sv
`default_nettype none

`include "ctrl_defs.svh"

package ctrlPkg;

	// ***********************************************************************
	// Instruction classes
	// ***********************************************************************

	typedef enum logic [2:0] {
		clsImplied,
		clsLdaImm,
		clsAndImm,
		clsLdaAbs,
		clsStaAbs,
		clsJmpAbs,
		clsJsr,
		clsRts
	} instrClassE;

	// ***********************************************************************
	// Cycle timer state
	// ***********************************************************************

	typedef struct packed {
		logic [`CYCLE_W-1:0] cycle;
		logic t0;    // Last cycle of the instruction.
		logic t1;    // Opcode fetch.
		logic t2;
		logic t6;
		logic t7;
		logic sync;
	} timingT;

	// ***********************************************************************
	// Decode lines
	// ***********************************************************************

	// Named replacements for the X[] outputs of the decode ROM.
	typedef struct packed {
		logic dlToAdl;      // X81, X82.
		logic sbToAc;       // X58 to X64.
		logic acToSb;       // X65 to X68.
		logic acToDb;       // X74.
		logic staOp;        // X79.
		logic jsr2;         // X48.
		logic jsr5;         // X56.
		logic jmp4;         // X101.
		logic rts5;         // X84.
		logic abs2;         // X83.
		logic implied;      // X128.
		logic ind;          // X89 to X91.
		logic pcToAdl;      // X71, X72.
		logic zAdh17Req;    // X57.
		logic incSbReq;     // X45 to X47.
	} decodeLinesT;

	// ***********************************************************************
	// Bus transfer strobes
	// ***********************************************************************

	typedef struct packed {
		logic zAdh0;
		logic zAdh17;
		logic sbAc;
		logic adlAbl;
		logic acSb;
		logic sbDb;
		logic acDb;
		logic sbAdh;
		logic dlAdh;
		logic dlAdl;
		logic adhAbh;
		logic dlDb;
		logic zTst;
		logic pgx;
	} busStrobesT;

endpackage

`default_nettype wire

// File: design/cycleTimer.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module cycleTimer (
	input logic PHI0,
	input logic rstN,
	input logic [`OPCODE_W-1:0] opcode,
	input logic ready,
	output ctrlPkg::timingT timing,
	output ctrlPkg::instrClassE instrClass
);

	logic [`OPCODE_W-1:0] irQ;
	logic [`CYCLE_W-1:0] cycleQ;
	logic [`CYCLE_W-1:0] classLen;
	logic lastCycle;

	// ***********************************************************************
	// Opcode classification
	// ***********************************************************************

	always_comb begin
		case (irQ)
			8'hA9: instrClass = ctrlPkg::clsLdaImm;
			8'h29: instrClass = ctrlPkg::clsAndImm;
			8'hAD: instrClass = ctrlPkg::clsLdaAbs;
			8'h8D: instrClass = ctrlPkg::clsStaAbs;
			8'h4C: instrClass = ctrlPkg::clsJmpAbs;
			8'h20: instrClass = ctrlPkg::clsJsr;
			8'h60: instrClass = ctrlPkg::clsRts;
			default: instrClass = ctrlPkg::clsImplied;
		endcase
	end

	always_comb begin
		case (instrClass)
			ctrlPkg::clsLdaImm, ctrlPkg::clsAndImm: classLen = `CYCLE_W'(`CYC_IMM);
			ctrlPkg::clsLdaAbs, ctrlPkg::clsStaAbs: classLen = `CYCLE_W'(`CYC_ABS);
			ctrlPkg::clsJmpAbs: classLen = `CYCLE_W'(`CYC_JMP);
			ctrlPkg::clsJsr: classLen = `CYCLE_W'(`CYC_JSR);
			ctrlPkg::clsRts: classLen = `CYCLE_W'(`CYC_RTS);
			default: classLen = `CYCLE_W'(`CYC_IMPL);
		endcase
	end

	assign lastCycle = cycleQ == classLen;

	// ***********************************************************************
	// Cycle counter
	// ***********************************************************************

	// Starts on a fetch with a NOP in the IR.
	always_ff @(posedge PHI0) begin
		if (!rstN) begin
			cycleQ <= `CYCLE_W'(1);
			irQ <= 8'hEA;
		end else if (ready) begin
			if (lastCycle) begin
				cycleQ <= `CYCLE_W'(1);
				irQ <= opcode;
			end else begin
				cycleQ <= cycleQ + `CYCLE_W'(1);
			end
		end
	end

	always_comb begin
		timing.cycle = cycleQ;
		timing.t0 = lastCycle;
		timing.t1 = cycleQ == `CYCLE_W'(1);
		timing.t2 = cycleQ == `CYCLE_W'(2);
		timing.t6 = cycleQ == `CYCLE_W'(6);
		timing.t7 = cycleQ == `CYCLE_W'(7);
		timing.sync = timing.t1;
	end

	// The IR only changes on a wrap, so the count stays inside the class.
	aCycleInRange: assert property (@(posedge PHI0) disable iff (!rstN)
		cycleQ >= `CYCLE_W'(1) && cycleQ <= classLen);

endmodule

`default_nettype wire

// File: design/decodeRom.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module decodeRom (
	input ctrlPkg::instrClassE instrClass,
	input ctrlPkg::timingT timing,
	output ctrlPkg::decodeLinesT lines
);

	logic cyc2;
	logic cyc3;
	logic cyc4;
	logic cyc5;
	logic cyc6;

	assign cyc2 = timing.cycle == `CYCLE_W'(2);
	assign cyc3 = timing.cycle == `CYCLE_W'(3);
	assign cyc4 = timing.cycle == `CYCLE_W'(4);
	assign cyc5 = timing.cycle == `CYCLE_W'(5);
	assign cyc6 = timing.cycle == `CYCLE_W'(6);

	always_comb begin
		lines = '0;

		// PC drives the address on every opcode fetch.
		lines.pcToAdl = timing.t1;

		case (instrClass)
			ctrlPkg::clsLdaImm: begin
				lines.pcToAdl = timing.t1 | cyc2;
				lines.sbToAc = timing.t0;
			end

			ctrlPkg::clsAndImm: begin
				lines.pcToAdl = timing.t1 | cyc2;
				lines.acToSb = timing.t0;
			end

			ctrlPkg::clsLdaAbs: begin
				lines.abs2 = cyc2;
				lines.dlToAdl = cyc3;
				lines.sbToAc = timing.t0;
			end

			ctrlPkg::clsStaAbs: begin
				lines.abs2 = cyc2;
				lines.dlToAdl = cyc3;
				// Write cycle.
				lines.acToDb = cyc4;
				lines.staOp = cyc4;
			end

			ctrlPkg::clsJmpAbs: begin
				lines.abs2 = cyc2;
				// High byte goes straight to ADH.
				lines.dlToAdl = cyc3;
				lines.ind = cyc3;
				// T4 in the original numbering.
				lines.jmp4 = timing.t0;
			end

			ctrlPkg::clsJsr: begin
				lines.jsr2 = cyc2;
				lines.zAdh17Req = cyc3 | cyc4;
				lines.jsr5 = cyc5;
				lines.ind = cyc6;
			end

			ctrlPkg::clsRts: begin
				lines.incSbReq = cyc3 | cyc4;
				lines.zAdh17Req = cyc3 | cyc4 | cyc5;
				lines.rts5 = cyc5;
			end

			default: begin
				lines.implied = cyc2;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/busControl.sv
`default_nettype none
`timescale 1ns/100ps

module busControl (
	input logic PHI0,
	input logic rstN,
	input ctrlPkg::decodeLinesT lines,
	input ctrlPkg::timingT timing,
	input logic ready,
	input logic andOp,
	input logic stor,
	input logic acrCarry,
	output ctrlPkg::busStrobesT strobes
);

	ctrlPkg::busStrobesT strobesNext;

	logic readyQ;
	logic incSb;
	logic sba;
	logic dlDbAbs;

	// ***********************************************************************
	// Gate equations
	// ***********************************************************************

	// Stack pointer increment or JSR operand fetch.
	assign incSb = lines.incSbReq | lines.jsr2;

	// Page carry onto ADH, only when the last cycle was not stalled.
	assign sba = lines.pcToAdl & acrCarry & readyQ;

	// Operand read at T0 except on a store.
	assign dlDbAbs = (lines.abs2 | (timing.t0 & !lines.staOp)) & !lines.implied;

	always_comb begin
		strobesNext.pgx = lines.pcToAdl;

		strobesNext.zAdh0 = lines.dlToAdl;
		strobesNext.zAdh17 = lines.zAdh17Req | lines.jsr5 | lines.dlToAdl;
		strobesNext.dlAdl = lines.dlToAdl;
		strobesNext.dlAdh = lines.ind | lines.rts5;

		strobesNext.sbAc = lines.sbToAc;
		// A load at T0 owns the special bus.
		strobesNext.acSb = (lines.acToSb | andOp) & !lines.sbToAc;
		strobesNext.acDb = lines.acToDb | (lines.staOp & stor);

		// No X/Y registers here, so only the AC path is tested.
		strobesNext.zTst = lines.sbToAc | andOp | timing.t7;
		strobesNext.sbDb = (strobesNext.zTst & !andOp) | lines.acToSb | timing.t1 |
			lines.jsr2;

		strobesNext.dlDb = dlDbAbs | incSb | lines.jmp4 | timing.t6;

		strobesNext.sbAdh = sba;
		strobesNext.adhAbh = sba | !incSb;

		// No ADL load during a stall or the RMW cycles.
		strobesNext.adlAbl = !lines.pcToAdl & ready & !timing.t6 & !timing.t7;
	end

	// ***********************************************************************
	// Output registers
	// ***********************************************************************

	always_ff @(posedge PHI0) begin
		if (!rstN) begin
			readyQ <= 1'b1;
			strobes <= '0;
		end else begin
			readyQ <= ready;
			strobes <= strobesNext;
		end
	end

	aDbExclusive: assert property (@(posedge PHI0) disable iff (!rstN)
		!(strobes.acDb && strobes.dlDb));

	aSbExclusive: assert property (@(posedge PHI0) disable iff (!rstN)
		!(strobes.sbAc && strobes.acSb));

endmodule

`default_nettype wire

// File: design/randomLogic.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module randomLogic (
	input logic PHI0,
	input logic rstN,
	input logic [`OPCODE_W-1:0] opcode,
	input logic ready,
	input logic andOp,
	input logic stor,
	input logic acrCarry,
	output ctrlPkg::timingT timing,
	output ctrlPkg::busStrobesT strobes
);

	ctrlPkg::instrClassE instrClass;
	ctrlPkg::decodeLinesT lines;

	cycleTimer uCycleTimer (
		.PHI0(PHI0),
		.rstN(rstN),
		.opcode(opcode),
		.ready(ready),
		.timing(timing),
		.instrClass(instrClass)
	);

	decodeRom uDecodeRom (
		.instrClass(instrClass),
		.timing(timing),
		.lines(lines)
	);

	busControl uBusControl (
		.PHI0(PHI0),
		.rstN(rstN),
		.lines(lines),
		.timing(timing),
		.ready(ready),
		.andOp(andOp),
		.stor(stor),
		.acrCarry(acrCarry),
		.strobes(strobes)
	);

endmodule

`default_nettype wire

// File: tb/randomLogicModel.svh
`ifndef RANDOM_LOGIC_MODEL_SVH
`define RANDOM_LOGIC_MODEL_SVH

// ***************************************************************************
// Reference model of the decode and timing slice
// ***************************************************************************

function automatic ctrlPkg::instrClassE classOf(input logic [`OPCODE_W-1:0] op);
	case (op)
		8'hA9: return ctrlPkg::clsLdaImm;
		8'h29: return ctrlPkg::clsAndImm;
		8'hAD: return ctrlPkg::clsLdaAbs;
		8'h8D: return ctrlPkg::clsStaAbs;
		8'h4C: return ctrlPkg::clsJmpAbs;
		8'h20: return ctrlPkg::clsJsr;
		8'h60: return ctrlPkg::clsRts;
		default: return ctrlPkg::clsImplied;
	endcase
endfunction

function automatic int classLength(input ctrlPkg::instrClassE cls);
	case (cls)
		ctrlPkg::clsLdaImm: return `CYC_IMM;
		ctrlPkg::clsAndImm: return `CYC_IMM;
		ctrlPkg::clsLdaAbs: return `CYC_ABS;
		ctrlPkg::clsStaAbs: return `CYC_ABS;
		ctrlPkg::clsJmpAbs: return `CYC_JMP;
		ctrlPkg::clsJsr: return `CYC_JSR;
		ctrlPkg::clsRts: return `CYC_RTS;
		default: return `CYC_IMPL;
	endcase
endfunction

function automatic ctrlPkg::timingT expectedTiming(input ctrlPkg::instrClassE cls,
		input logic [`CYCLE_W-1:0] cycle);
	ctrlPkg::timingT t;
	t.cycle = cycle;
	t.t0 = cycle == classLength(cls);
	t.t1 = cycle == 1;
	t.t2 = cycle == 2;
	t.t6 = cycle == 6;
	t.t7 = cycle == 7;
	t.sync = cycle == 1;
	return t;
endfunction

// Strobes that the DUT shows one cycle after the given state.
function automatic ctrlPkg::busStrobesT expectedStrobes(input ctrlPkg::instrClassE cls,
		input logic [`CYCLE_W-1:0] cycle, input logic readyIn, input logic readyHist,
		input logic andIn, input logic carryIn);
	ctrlPkg::busStrobesT s;
	logic last;
	logic fetch;
	logic isAbs;
	logic pcAddr;
	logic dlAddr;
	logic loadAc;
	logic andAc;
	logic staWrite;
	logic jsrOperand;
	logic stackInc;
	logic impliedLast;
	last = cycle == classLength(cls);
	fetch = cycle == 1;
	isAbs = cls inside {ctrlPkg::clsLdaAbs, ctrlPkg::clsStaAbs, ctrlPkg::clsJmpAbs};
	pcAddr = fetch | (cls inside {ctrlPkg::clsLdaImm, ctrlPkg::clsAndImm} && cycle == 2);
	dlAddr = isAbs && cycle == 3;
	loadAc = cls inside {ctrlPkg::clsLdaImm, ctrlPkg::clsLdaAbs} && last;
	andAc = cls == ctrlPkg::clsAndImm && last;
	staWrite = cls == ctrlPkg::clsStaAbs && cycle == 4;
	jsrOperand = cls == ctrlPkg::clsJsr && cycle == 2;
	stackInc = jsrOperand | (cls == ctrlPkg::clsRts && cycle inside {3, 4});
	impliedLast = cls == ctrlPkg::clsImplied && cycle == 2;

	s.pgx = pcAddr;
	s.zAdh0 = dlAddr;
	s.dlAdl = dlAddr;
	s.zAdh17 = dlAddr | (cls inside {ctrlPkg::clsJsr, ctrlPkg::clsRts} && cycle inside {3, 4, 5});
	s.dlAdh = (cls == ctrlPkg::clsJmpAbs && cycle == 3) | (cls == ctrlPkg::clsJsr && cycle == 6) |
		(cls == ctrlPkg::clsRts && cycle == 5);
	s.sbAc = loadAc;
	s.acSb = (andAc | andIn) & !loadAc;
	// STA puts AC on DB in its write cycle.
	s.acDb = staWrite;
	s.zTst = loadAc | andIn;
	s.sbDb = (loadAc & !andIn) | andAc | fetch | jsrOperand;
	s.dlDb = (((isAbs && cycle == 2) | (last & !staWrite)) & !impliedLast) | stackInc |
		(cls == ctrlPkg::clsJmpAbs && last) | (cycle == 6);
	s.sbAdh = pcAddr & carryIn & readyHist;
	s.adhAbh = s.sbAdh | !stackInc;
	s.adlAbl = !pcAddr & readyIn & (cycle != 6) & (cycle != 7);
	return s;
endfunction

`endif

// File: tb/randomLogicTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module randomLogicTb;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 10;
	localparam int numInstr = 600;
	localparam int maxInstrCycles = 8;
	localparam int watchdogNs = (resetCycles + numInstr * maxInstrCycles) * clkPeriod;

	logic PHI0;
	logic rstN;
	logic [`OPCODE_W-1:0] opcode;
	logic ready;
	logic andOp;
	logic stor;
	logic acrCarry;
	ctrlPkg::timingT timing;
	ctrlPkg::busStrobesT strobes;

	// Model state.
	ctrlPkg::instrClassE modelClass;
	logic [`CYCLE_W-1:0] modelCycle;
	logic modelReadyQ;
	ctrlPkg::busStrobesT modelStrobes;
	int instrCount = 0;

	int errorCount = 0;
	int checkCount = 0;
	logic resetSeen = 1'b0;
	logic havePrev = 1'b0;
	logic prevReady;
	ctrlPkg::timingT prevTiming;

	`include "randomLogicModel.svh"

	randomLogic DUT (
		.PHI0(PHI0),
		.rstN(rstN),
		.opcode(opcode),
		.ready(ready),
		.andOp(andOp),
		.stor(stor),
		.acrCarry(acrCarry),
		.timing(timing),
		.strobes(strobes)
	);

	initial begin
		PHI0 = 1'b0;
		forever #(clkPeriod / 2) PHI0 = ~PHI0;
	end

	function automatic logic [`OPCODE_W-1:0] randomOpcode();
		logic [`OPCODE_W-1:0] known [7];
		known = '{8'hA9, 8'h29, 8'hAD, 8'h8D, 8'h4C, 8'h20, 8'h60};
		if ($urandom_range(9, 0) < 7)
			return known[$urandom_range(6, 0)];
		return `OPCODE_W'($urandom);
	endfunction

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("MISMATCH %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ***********************************************************************
	// Reference sequence
	// ***********************************************************************

	always @(posedge PHI0) begin
		if (!rstN) begin
			modelClass <= ctrlPkg::clsImplied;
			modelCycle <= `CYCLE_W'(1);
			modelReadyQ <= 1'b1;
			modelStrobes <= '0;
		end else begin
			modelStrobes <= expectedStrobes(modelClass, modelCycle, ready, modelReadyQ,
				andOp, acrCarry);
			modelReadyQ <= ready;
			if (ready) begin
				if (modelCycle == classLength(modelClass)) begin
					modelCycle <= `CYCLE_W'(1);
					modelClass <= classOf(opcode);
					instrCount <= instrCount + 1;
				end else begin
					modelCycle <= modelCycle + `CYCLE_W'(1);
				end
			end
		end
	end

	// ***********************************************************************
	// Comparison at mid cycle
	// ***********************************************************************

	always @(negedge PHI0) begin
		if (rstN) begin
			checkCount++;
			if (timing !== expectedTiming(modelClass, modelCycle)) begin
				errorCount++;
				$display("MISMATCH %0t timing: got %b expected %b", $time, timing,
					expectedTiming(modelClass, modelCycle));
			end
			checkBit("zAdh0", strobes.zAdh0, modelStrobes.zAdh0);
			checkBit("zAdh17", strobes.zAdh17, modelStrobes.zAdh17);
			checkBit("sbAc", strobes.sbAc, modelStrobes.sbAc);
			checkBit("adlAbl", strobes.adlAbl, modelStrobes.adlAbl);
			checkBit("acSb", strobes.acSb, modelStrobes.acSb);
			checkBit("sbDb", strobes.sbDb, modelStrobes.sbDb);
			checkBit("acDb", strobes.acDb, modelStrobes.acDb);
			checkBit("sbAdh", strobes.sbAdh, modelStrobes.sbAdh);
			checkBit("dlAdh", strobes.dlAdh, modelStrobes.dlAdh);
			checkBit("dlAdl", strobes.dlAdl, modelStrobes.dlAdl);
			checkBit("adhAbh", strobes.adhAbh, modelStrobes.adhAbh);
			checkBit("dlDb", strobes.dlDb, modelStrobes.dlDb);
			checkBit("zTst", strobes.zTst, modelStrobes.zTst);
			checkBit("pgx", strobes.pgx, modelStrobes.pgx);

			if (!resetSeen) begin
				resetSeen = 1'b1;
				if (strobes !== '0 || timing.cycle !== `CYCLE_W'(1) || timing.sync !== 1'b1) begin
					errorCount++;
					$display("%0t: first cycle after reset is not a clean fetch", $time);
				end
			end

			// A stalled cycle leaves the timer alone and blocks the ADL load.
			if (havePrev && !prevReady) begin
				if (timing !== prevTiming || strobes.adlAbl !== 1'b0) begin
					errorCount++;
					$display("%0t: timer moved or adlAbl set after a stalled cycle", $time);
				end
			end

			if (strobes.acDb && strobes.dlDb) begin
				errorCount++;
				$display("%0t: acDb and dlDb are both high", $time);
			end
			if (strobes.sbAc && strobes.acSb) begin
				errorCount++;
				$display("%0t: sbAc and acSb are both high", $time);
			end

			prevTiming = timing;
			prevReady = ready;
			havePrev = 1'b1;
		end
	end

	// ***********************************************************************
	// Stimulus and report
	// ***********************************************************************

	initial begin
		void'($urandom(93));
		rstN = 1'b0;
		opcode = 8'hEA;
		ready = 1'b1;
		andOp = 1'b0;
		stor = 1'b0;
		acrCarry = 1'b0;
		repeat (resetCycles) @(posedge PHI0);
		#1 rstN = 1'b1;

		while (instrCount < numInstr) begin
			@(posedge PHI0);
			#1;
			opcode = randomOpcode();
			ready = $urandom_range(4, 0) != 0;
			andOp = $urandom_range(7, 0) == 0;
			stor = $urandom_range(1, 0);
			acrCarry = $urandom_range(1, 0);
		end
		repeat (2) @(posedge PHI0);

		$display("Instructions: %0d, checks: %0d, errors: %0d", instrCount, checkCount,
			errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("Timeout: %0d instructions did not finish in time", numInstr);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
+incdir+tb
design/ctrlPkg.sv
design/cycleTimer.sv
design/decodeRom.sv
design/busControl.sv
design/randomLogic.sv
tb/randomLogicTb.sv

// File: Bender.yml
package:
  name: randomLogic

sources:
  - include_dirs:
      - design
    files:
      - design/ctrlPkg.sv
      - design/cycleTimer.sv
      - design/decodeRom.sv
      - design/busControl.sv
      - design/randomLogic.sv
  - target: test
    include_dirs:
      - design
      - tb
    files:
      - tb/randomLogicTb.sv
